// ==== rtl/mini_mcu_consts.svh ====
/* address map, RAM depth and register offsets of the mini MCU,
   included by the RTL and the testbench */
`ifndef MINI_MCU_CONSTS_SVH
`define MINI_MCU_CONSTS_SVH

`define MCU_RAM_WORDS 1024

// region codes live in addr[31:28]
`define MCU_REGION_RAM    4'h0
`define MCU_REGION_PERIPH 4'h1

`define MCU_REG_DMA_SRC    12'h000
`define MCU_REG_DMA_DST    12'h004
`define MCU_REG_DMA_LEN    12'h008
`define MCU_REG_DMA_STATUS 12'h00C
`define MCU_REG_EXIT       12'h010
`endif

// ==== rtl/mini_mcu_pkg.sv ====
/* bus and copy-engine types shared by all blocks of the mini MCU */
package mini_mcu_pkg;

  // master to slave request
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // slave to master response
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // decoder reads the region, slaves read the word index
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [3:0]  region;
      logic [15:0] unused;
      logic [9:0]  word_idx;
      logic [1:0]  byte_off;
    } f;
  } bus_addr_u;

  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [13:0] len;
    logic        start;
  } dma_cfg_t;

  typedef struct packed {
    logic busy;
    logic done;
  } dma_status_t;

endpackage

// ==== rtl/system_bus.sv ====
/* two-master system bus: round-robin arbitration between host and DMA,
   region decode to RAM or peripherals, response routing one cycle later */
`timescale 1ns/1ps
`include "mini_mcu_consts.svh"

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  host_req_i,
  output obi_resp_t host_resp_o,
  input  obi_req_t  dma_req_i,
  output obi_resp_t dma_resp_o,
  output obi_req_t  ram_req_o,
  input  obi_resp_t ram_resp_i,
  output obi_req_t  periph_req_o,
  input  obi_resp_t periph_resp_i
);

  logic        last_dma_q;
  logic        sel_dma;
  logic        host_win;
  obi_req_t    win_req;
  bus_addr_u   win_addr;
  logic        to_ram;
  logic        to_periph;
  logic        slv_gnt;
  logic        granted;
  logic        rsp_dma_q;
  logic        rsp_ram_q;
  logic        rsp_periph_q;
  logic        rsp_none_q;
  logic        rsp_rvalid;
  logic [31:0] rsp_rdata;

  // on contention the master that lost last time wins
  assign sel_dma  = dma_req_i.req & (~host_req_i.req | ~last_dma_q);
  assign host_win = host_req_i.req & ~sel_dma;
  assign win_req  = sel_dma ? dma_req_i : host_req_i;
  assign win_addr = win_req.addr;

  assign to_ram    = (win_addr.f.region == `MCU_REGION_RAM);
  assign to_periph = (win_addr.f.region == `MCU_REGION_PERIPH);

  always_comb begin
    ram_req_o        = win_req;
    ram_req_o.req    = win_req.req & to_ram;
    periph_req_o     = win_req;
    periph_req_o.req = win_req.req & to_periph;
  end

  // unmapped regions are always granted
  assign slv_gnt = to_ram ? ram_resp_i.gnt : (to_periph ? periph_resp_i.gnt : 1'b1);
  assign granted = win_req.req & slv_gnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_dma_q   <= 1'b0;
      rsp_dma_q    <= 1'b0;
      rsp_ram_q    <= 1'b0;
      rsp_periph_q <= 1'b0;
      rsp_none_q   <= 1'b0;
    end else begin
      if (granted) begin
        last_dma_q <= sel_dma;
      end
      rsp_dma_q    <= sel_dma;
      rsp_ram_q    <= granted & to_ram;
      rsp_periph_q <= granted & to_periph;
      rsp_none_q   <= granted & ~to_ram & ~to_periph;
    end
  end

  // unmapped access answers with zero data
  always_comb begin
    rsp_rvalid = (rsp_ram_q & ram_resp_i.rvalid) | (rsp_periph_q & periph_resp_i.rvalid) |
                 rsp_none_q;
    rsp_rdata  = '0;
    if (rsp_ram_q) begin
      rsp_rdata = ram_resp_i.rdata;
    end else if (rsp_periph_q) begin
      rsp_rdata = periph_resp_i.rdata;
    end
  end

  assign host_resp_o.gnt    = host_win & granted;
  assign host_resp_o.rvalid = rsp_rvalid & ~rsp_dma_q;
  assign host_resp_o.rdata  = rsp_rdata;
  assign dma_resp_o.gnt     = sel_dma & granted;
  assign dma_resp_o.rvalid  = rsp_rvalid & rsp_dma_q;
  assign dma_resp_o.rdata   = rsp_rdata;

endmodule

// ==== rtl/ram_bank.sv ====
/* single-port word RAM with byte enables, always grants and
   answers every access one cycle later */
`timescale 1ns/1ps
`include "mini_mcu_consts.svh"

module ram_bank
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [31:0] mem [`MCU_RAM_WORDS];
  bus_addr_u   addr;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  assign addr = req_i.addr;

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[addr.f.word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr.f.word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= req_i.req;
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

endmodule

// ==== rtl/dma_channel.sv ====
/* single-channel copy engine, moves len words from src to dst
   with one bus read followed by one bus write per word */
`timescale 1ns/1ps

module dma_channel
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  dma_cfg_t    cfg_i,
  input  logic        dma_done_clr_i,
  output dma_status_t status_o,
  output obi_req_t    bus_req_o,
  input  obi_resp_t   bus_resp_i
);

  localparam logic [2:0] S_IDLE       = 3'd0;
  localparam logic [2:0] S_READ       = 3'd1;
  localparam logic [2:0] S_READ_WAIT  = 3'd2;
  localparam logic [2:0] S_WRITE      = 3'd3;
  localparam logic [2:0] S_WRITE_WAIT = 3'd4;

  logic [2:0]  state_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [13:0] cnt_q;
  logic [31:0] data_q;
  logic        done_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      if (dma_done_clr_i) done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          // zero length starts are dropped
          if (cfg_i.start && cfg_i.len != '0) begin
            src_q   <= cfg_i.src;
            dst_q   <= cfg_i.dst;
            cnt_q   <= cfg_i.len;
            done_q  <= 1'b0;
            state_q <= S_READ;
          end
        end
        S_READ:      if (bus_resp_i.gnt) state_q <= S_READ_WAIT;
        S_READ_WAIT: if (bus_resp_i.rvalid) state_q <= S_WRITE;
        S_WRITE:     if (bus_resp_i.gnt) state_q <= S_WRITE_WAIT;
        S_WRITE_WAIT: begin
          if (bus_resp_i.rvalid) begin
            src_q <= src_q + 32'd4;
            dst_q <= dst_q + 32'd4;
            cnt_q <= cnt_q - 14'd1;
            if (cnt_q == 14'd1) begin
              done_q  <= 1'b1;
              state_q <= S_IDLE;
            end else begin
              state_q <= S_READ;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // word held between its read and its write
  always_ff @(posedge clk_i) begin
    if (state_q == S_READ_WAIT && bus_resp_i.rvalid) data_q <= bus_resp_i.rdata;
  end

  assign bus_req_o.req   = (state_q == S_READ) || (state_q == S_WRITE);
  assign bus_req_o.we    = (state_q == S_WRITE);
  assign bus_req_o.be    = 4'hf;
  assign bus_req_o.addr  = (state_q == S_WRITE) ? dst_q : src_q;
  assign bus_req_o.wdata = data_q;

  assign status_o.busy = (state_q != S_IDLE);
  assign status_o.done = done_q;

endmodule

// ==== rtl/ao_periph_regs.sv ====
/* always-on register block: copy-engine source, destination, length and
   status, completion interrupt and the exit value */
`timescale 1ns/1ps
`include "mini_mcu_consts.svh"

module ao_periph_regs
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  obi_req_t    req_i,
  output obi_resp_t   resp_o,
  output dma_cfg_t    dma_cfg_o,
  input  dma_status_t dma_status_i,
  output logic        dma_done_clr_o,
  output logic        intr_o,
  output logic [31:0] exit_value_o
);

  bus_addr_u   addr;
  logic [11:0] reg_off;
  logic [31:0] src_q, dst_q, exit_q, rd_word, rdata_q;
  logic [13:0] len_q;
  logic        start_q, clr_q, rvalid_q, intr_q;

  assign addr    = req_i.addr;
  assign reg_off = {addr.f.word_idx, 2'b00};

  always_comb begin
    case (reg_off)
      `MCU_REG_DMA_SRC:    rd_word = src_q;
      `MCU_REG_DMA_DST:    rd_word = dst_q;
      `MCU_REG_DMA_LEN:    rd_word = {18'd0, len_q};
      `MCU_REG_DMA_STATUS: rd_word = {30'd0, dma_status_i.done, dma_status_i.busy};
      `MCU_REG_EXIT:       rd_word = exit_q;
      default:             rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      {src_q, dst_q, exit_q, len_q} <= '0;
      {start_q, clr_q, rvalid_q, intr_q} <= '0;
    end else begin
      start_q  <= 1'b0;
      clr_q    <= 1'b0;
      rvalid_q <= req_i.req;
      intr_q   <= dma_status_i.done;
      if (req_i.req && req_i.we) begin
        case (reg_off)
          `MCU_REG_DMA_SRC: src_q <= req_i.wdata;
          `MCU_REG_DMA_DST: dst_q <= req_i.wdata;
          // length write also kicks off the copy
          `MCU_REG_DMA_LEN: begin
            len_q   <= req_i.wdata[13:0];
            start_q <= 1'b1;
          end
          `MCU_REG_DMA_STATUS: clr_q <= 1'b1;
          `MCU_REG_EXIT:       exit_q <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= req_i.we ? 32'd0 : rd_word;
  end

  assign resp_o         = '{gnt: req_i.req, rvalid: rvalid_q, rdata: rdata_q};
  assign dma_cfg_o      = '{src: src_q, dst: dst_q, len: len_q, start: start_q};
  assign dma_done_clr_o = clr_q;
  assign intr_o         = intr_q;
  assign exit_value_o   = exit_q;

endmodule

// ==== rtl/mini_mcu.sv ====
/* mini MCU top level: host port and copy engine share the system bus
   in front of the RAM bank and the always-on register block */
`timescale 1ns/1ps

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  obi_req_t    host_req_i,
  output obi_resp_t   host_resp_o,
  output logic        intr_o,
  output logic [31:0] exit_value_o
);

  obi_req_t    dma_req, ram_req, periph_req;
  obi_resp_t   dma_resp, ram_resp, periph_resp;
  dma_cfg_t    dma_cfg;
  dma_status_t dma_status;
  logic        dma_done_clr;

  system_bus u_system_bus (
    .clk_i, .rst_n_i,
    .host_req_i, .host_resp_o,
    .dma_req_i(dma_req), .dma_resp_o(dma_resp),
    .ram_req_o(ram_req), .ram_resp_i(ram_resp),
    .periph_req_o(periph_req), .periph_resp_i(periph_resp)
  );

  ram_bank u_ram_bank (
    .clk_i, .rst_n_i,
    .req_i(ram_req), .resp_o(ram_resp)
  );

  dma_channel u_dma_channel (
    .clk_i, .rst_n_i,
    .cfg_i(dma_cfg), .dma_done_clr_i(dma_done_clr), .status_o(dma_status),
    .bus_req_o(dma_req), .bus_resp_i(dma_resp)
  );

  ao_periph_regs u_ao_periph_regs (
    .clk_i, .rst_n_i,
    .req_i(periph_req), .resp_o(periph_resp),
    .dma_cfg_o(dma_cfg), .dma_status_i(dma_status), .dma_done_clr_o(dma_done_clr),
    .intr_o, .exit_value_o
  );

endmodule

// ==== bench/mini_mcu_props.sv ====
/* concurrent checks on the host port and the copy-engine status,
   bound into the mini MCU top level by the testbench */
`timescale 1ns/1ps

module mini_mcu_props
  import mini_mcu_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input obi_req_t    host_req_i,
  input obi_resp_t   host_resp_i,
  input logic        intr_i,
  input dma_status_t dma_status_i
);

  // a grant only answers a pending request
  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_i.gnt |-> host_req_i.req)
    else $error("host grant without a request");

  a_gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_i.gnt |=> host_resp_i.rvalid)
    else $error("host grant not followed by rvalid");

  a_intr_not_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(intr_i) |-> !dma_status_i.busy)
    else $error("interrupt rose while the copy engine was busy");

endmodule

// ==== bench/tb_mini_mcu.sv ====
/* directed testbench of the mini MCU, drives the host port against
   a RAM model and checks registers, copy engine and unmapped accesses */
`timescale 1ns/1ps
`include "mini_mcu_consts.svh"

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam logic [31:0] REGS = {`MCU_REGION_PERIPH, 28'h0};

  logic        clk = 1'b0;
  logic        rst_n;
  obi_req_t    host_req;
  obi_resp_t   host_resp;
  logic        intr;
  logic [31:0] exit_value;
  logic [31:0] ref_mem [`MCU_RAM_WORDS];
  integer      seed = 32'hec01;
  int          checks = 0;
  int          errors = 0;

  mini_mcu u_mini_mcu (
    .clk_i(clk), .rst_n_i(rst_n),
    .host_req_i(host_req), .host_resp_o(host_resp),
    .intr_o(intr), .exit_value_o(exit_value)
  );

  bind mini_mcu mini_mcu_props u_mini_mcu_props (
    .clk_i, .rst_n_i, .host_req_i, .host_resp_i(host_resp_o),
    .intr_i(intr_o), .dma_status_i(dma_status)
  );

  always #4 clk = ~clk;

  task automatic check_data(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_status(input string what, input dma_status_t got, input dma_status_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  // one host access, request held until granted, then wait for rvalid
  task automatic host_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    rdata = '0;
    @(posedge clk);
    host_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!host_resp.gnt && n < 64);
    host_req.req <= 1'b0;
    if (!host_resp.gnt) begin
      errors++;
      $display("host access to 0x%h was never granted", addr);
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!host_resp.rvalid && n < 64);
    if (!host_resp.rvalid) begin
      errors++;
      $display("host access to 0x%h got no response", addr);
      return;
    end
    rdata = host_resp.rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] unused;
    host_access(1'b1, be, addr, data, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    host_access(1'b0, 4'hf, addr, 32'd0, data);
  endtask

  task automatic ram_write(input logic [9:0] idx, input logic [31:0] d, input logic [3:0] be);
    logic [31:0] m;
    m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    bus_write({20'h0, idx, 2'b00}, d, be);
    ref_mem[idx] = (ref_mem[idx] & ~m) | (d & m);
  endtask

  task automatic ram_check(input logic [9:0] idx);
    logic [31:0] d;
    bus_read({20'h0, idx, 2'b00}, d);
    check_data($sformatf("ram[%0d]", idx), d, ref_mem[idx]);
  endtask

  task automatic read_status(output dma_status_t st);
    logic [31:0] w;
    bus_read(REGS + `MCU_REG_DMA_STATUS, w);
    st.busy = w[0];
    st.done = w[1];
  endtask

  // program the engine and move the words in the model right away
  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst, input int len);
    bus_write(REGS + `MCU_REG_DMA_SRC, src, 4'hf);
    bus_write(REGS + `MCU_REG_DMA_DST, dst, 4'hf);
    bus_write(REGS + `MCU_REG_DMA_LEN, len, 4'hf);
    for (int i = 0; i < len; i++) begin
      ref_mem[10'(dst[11:2] + i)] = ref_mem[10'(src[11:2] + i)];
    end
  endtask

  task automatic wait_done();
    dma_status_t st;
    int n = 0;
    do begin
      read_status(st);
      n++;
    end while (!st.done && n < 200);
    if (!st.done) begin
      errors++;
      $display("copy engine never reported done");
    end
    check_status("status at end", st, '{busy: 1'b0, done: 1'b1});
    check_data("intr_o", {31'd0, intr}, 32'd1);
  endtask

  task automatic clear_done();
    dma_status_t st;
    bus_write(REGS + `MCU_REG_DMA_STATUS, 32'd0, 4'hf);
    read_status(st);
    check_status("status after clear", st, '{busy: 1'b0, done: 1'b0});
    check_data("intr_o", {31'd0, intr}, 32'd0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: %s", name, (errors == errs_before) ? "ok" : "errors");
  endtask

  task automatic test_ram_words();
    int e = errors;
    for (int i = 0; i < 16; i++) ram_write(10'(i), $random(seed), 4'hf);
    for (int i = 0; i < 16; i++) ram_check(10'(i));
    report_test("ram full words", e);
  endtask

  task automatic test_byte_enables();
    int e = errors;
    for (int i = 0; i < 16; i++) ram_write(10'(i), $random(seed), 4'(i));
    for (int i = 0; i < 16; i++) ram_check(10'(i));
    report_test("ram byte enables", e);
  endtask

  task automatic test_exit_reg();
    int e = errors;
    logic [31:0] v = $random(seed);
    logic [31:0] d;
    bus_write(REGS + `MCU_REG_EXIT, v, 4'hf);
    check_data("exit_value_o", exit_value, v);
    bus_read(REGS + `MCU_REG_EXIT, d);
    check_data("exit rdata", d, v);
    report_test("exit register", e);
  endtask

  task automatic test_copy();
    int e = errors;
    dma_status_t st;
    for (int i = 0; i < 8; i++) ram_write(10'(64 + i), $random(seed), 4'hf);
    start_copy(32'h100, 32'h200, 8);
    read_status(st);
    check_status("status after start", st, '{busy: 1'b1, done: 1'b0});
    wait_done();
    clear_done();
    for (int i = 0; i < 8; i++) ram_check(10'(128 + i));
    report_test("dma copy", e);
  endtask

  // host traffic to its own area while the engine owns the bus too
  task automatic test_contention();
    int e = errors;
    for (int i = 0; i < 8; i++) ram_write(10'(192 + i), $random(seed), 4'hf);
    start_copy(32'h300, 32'h380, 8);
    for (int i = 0; i < 8; i++) ram_write(10'(384 + i), $random(seed), 4'hf);
    for (int i = 0; i < 8; i++) ram_check(10'(384 + i));
    wait_done();
    clear_done();
    for (int i = 0; i < 8; i++) ram_check(10'(224 + i));
    report_test("host and dma contention", e);
  endtask

  task automatic test_unmapped();
    int e = errors;
    logic [31:0] d;
    bus_read(32'h3000_0020, d);
    check_data("unmapped rdata", d, 32'h0);
    bus_write(32'h3000_0020, 32'hdead_beef, 4'hf);
    ram_check(10'd8);
    report_test("unmapped region", e);
  endtask

  initial begin
    host_req <= '0;
    rst_n    <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_ram_words();
    test_byte_enables();
    test_exit_reg();
    test_copy();
    test_contention();
    test_unmapped();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (20000) @(posedge clk);
    $display("simulation ran too long, stopping");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/mini_mcu_pkg.sv
rtl/system_bus.sv
rtl/ram_bank.sv
rtl/dma_channel.sv
rtl/ao_periph_regs.sv
rtl/mini_mcu.sv
bench/mini_mcu_props.sv
bench/tb_mini_mcu.sv

// ==== Makefile ====
SIM  = obj_dir/Vtb_mini_mcu
SRCS = filelist.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert --top-module tb_mini_mcu -f filelist.f

run: $(SIM)
	$(SIM) | tee sim.log
	@! grep -q "Result: FAILED" sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
